// ==== logic/csr_pkg.sv ====
// CSR unit shared definitions
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;
    localparam int COUNTER_W = 64;
    localparam int ADDR_W = 12;
    localparam int ECODE_W = 5;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [COUNTER_W-1:0] counter_t;
    typedef logic [ADDR_W-1:0] csr_addr_t;
    typedef logic [ECODE_W-1:0] ecode_t;
    // Instructions retired per cycle, 0 to 2
    typedef logic [1:0] retire_cnt_t;

    // Encoded as the low bits of funct3
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef enum logic [4:0] {
        SEL_MISA, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID,
        SEL_MSTATUS, SEL_MTVEC, SEL_MIE, SEL_MIP,
        SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL,
        SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_NONE
    } csr_sel_t;

    ////////////////////////////////////////
    // CSR addresses
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    ////////////////////////////////////////
    // Constant register values
    // mxlen 1, M and I extensions
    localparam xlen_t MISA_VALUE = 32'h4000_1100;
    localparam xlen_t HART_ID = 32'h0000_0000;

    ////////////////////////////////////////
    // Trap causes and register masks
    localparam ecode_t M_SW_CODE    = 5'd3;
    localparam ecode_t M_TIMER_CODE = 5'd7;
    localparam ecode_t M_EXT_CODE   = 5'd11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam xlen_t MSTATUS_MASK  = 32'h0000_0088;
    // mpp is hard wired to machine mode
    localparam xlen_t MSTATUS_MPP_M = 32'h0000_1800;

    // mip uses the same bit positions
    localparam xlen_t MIE_MASK = 32'h0000_0888;

    // Legal mcause codes, indexed by code
    // Exceptions: misaligned fetch, illegal, break, misaligned load/store, ecall
    localparam logic [31:0] EXC_CODE_LEGAL = 32'h0000_085D;
    localparam logic [31:0] INT_CODE_LEGAL = 32'h0000_0888;

endpackage

`default_nettype wire

// ==== logic/csr_cmd_if.sv ====
// Decoded CSR command
`default_nettype none

interface csr_cmd_if
    import csr_pkg::*;
();

    // One cycle after the request is accepted
    logic commit;
    csr_sel_t sel;
    csr_op_t op;
    xlen_t wdata;
    logic writable;

    modport decode (
        output commit,
        output sel,
        output op,
        output wdata,
        output writable
    );

    modport execute (
        input commit,
        input sel,
        input op,
        input wdata,
        input writable
    );

endinterface

`default_nettype wire

// ==== logic/csr_decode.sv ====
// CSR request decode
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    output logic      issue_ready,
    input  csr_op_t   issue_op,
    input  csr_addr_t issue_addr,
    input  xlen_t     issue_wdata,
    input  logic      result_ack,
    csr_cmd_if.decode cmd
);

    logic busy;
    logic committed;
    logic accept;
    logic commit;
    csr_sel_t issue_sel;

    function automatic csr_sel_t decode_sel(input csr_addr_t addr);
        case (addr)
            ADDR_MISA:      return SEL_MISA;
            ADDR_MVENDORID: return SEL_MVENDORID;
            ADDR_MARCHID:   return SEL_MARCHID;
            ADDR_MIMPID:    return SEL_MIMPID;
            ADDR_MHARTID:   return SEL_MHARTID;
            ADDR_MSTATUS:   return SEL_MSTATUS;
            ADDR_MTVEC:     return SEL_MTVEC;
            ADDR_MIE:       return SEL_MIE;
            ADDR_MIP:       return SEL_MIP;
            ADDR_MSCRATCH:  return SEL_MSCRATCH;
            ADDR_MEPC:      return SEL_MEPC;
            ADDR_MCAUSE:    return SEL_MCAUSE;
            ADDR_MTVAL:     return SEL_MTVAL;
            ADDR_MCYCLE:    return SEL_MCYCLE;
            ADDR_MCYCLEH:   return SEL_MCYCLEH;
            ADDR_MINSTRET:  return SEL_MINSTRET;
            ADDR_MINSTRETH: return SEL_MINSTRETH;
            default:        return SEL_NONE;
        endcase
    endfunction

    assign issue_ready = ~busy;
    assign accept = issue_valid & issue_ready;
    assign issue_sel = decode_sel(issue_addr);

    // Busy until the result is acknowledged
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            committed <= 1'b0;
        end else begin
            busy <= accept | (busy & ~(committed & result_ack));
            if (accept)
                committed <= 1'b0;
            else if (commit)
                committed <= 1'b1;
        end
    end

    assign commit = busy & ~committed;
    assign cmd.commit = commit;

    // Request latch
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.sel <= issue_sel;
            cmd.op <= issue_op;
            cmd.wdata <= issue_wdata;
            // Top address bits 11 mark a read-only CSR
            cmd.writable <= (issue_addr[11:10] != 2'b11) && (issue_sel != SEL_NONE);
        end
    end

    // A stalled request stays on the issue port until accepted
    assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_addr));

endmodule

`default_nettype wire

// ==== logic/csr_execute.sv ====
// CSR read-modify-write and result
`default_nettype none

module csr_execute
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    csr_cmd_if.execute cmd,
    input  xlen_t      rd_regs,
    input  xlen_t      rd_count,
    output logic       wr_en,
    output csr_sel_t   wr_sel,
    output xlen_t      wr_data,
    output logic       result_done,
    output xlen_t      result_rdata,
    input  logic       result_ack
);

    xlen_t old_value;
    xlen_t new_value;

    // Each register block returns zero outside its own selects
    assign old_value = rd_regs | rd_count;

    always_comb begin
        case (cmd.op)
            CSR_RS:  new_value = old_value | cmd.wdata;
            CSR_RC:  new_value = old_value & ~cmd.wdata;
            default: new_value = cmd.wdata;
        endcase
    end

    ////////////////////////////////////////
    // Write strobe and done flag
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
            result_done <= 1'b0;
        end else begin
            wr_en <= cmd.commit & cmd.writable;
            result_done <= (result_done & ~result_ack) | cmd.commit;
        end
    end

    // Old value held for the result, new value for the write
    always_ff @(posedge clk) begin
        if (cmd.commit) begin
            result_rdata <= old_value;
            wr_data <= new_value;
            wr_sel <= cmd.sel;
        end
    end

    // Writes only reach a decoded address
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (wr_sel != SEL_NONE));

endmodule

`default_nettype wire

// ==== logic/csr_machine_regs.sv ====
// Machine trap registers
`default_nettype none

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  csr_sel_t wr_sel,
    input  xlen_t    wr_data,
    input  csr_sel_t rd_sel,
    output xlen_t    rd_regs,
    input  logic     exception_valid,
    input  ecode_t   exception_code,
    input  xlen_t    exception_tval,
    input  logic     interrupt_take,
    input  xlen_t    trap_pc,
    input  logic     mret,
    input  logic     m_software,
    input  logic     m_timer,
    input  logic     m_external,
    output logic     interrupt_pending,
    output xlen_t    trap_vector,
    output xlen_t    epc
);

    xlen_t mstatus_q;
    xlen_t mtvec_q;
    xlen_t mie_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mtval_q;
    logic mcause_int;
    ecode_t mcause_code;
    logic msip;
    logic mtip;
    logic meip;

    xlen_t mip_value;
    xlen_t int_active;
    ecode_t int_code;
    logic trap_enter;
    logic cause_legal;

    function automatic logic wr_hit(input csr_sel_t sel);
        return wr_en && (wr_sel == sel);
    endfunction

    assign trap_enter = interrupt_take | exception_valid;

    ////////////////////////////////////////
    // Interrupts
    always_comb begin
        mip_value = '0;
        mip_value[M_SW_CODE] = msip;
        mip_value[M_TIMER_CODE] = mtip;
        mip_value[M_EXT_CODE] = meip;
    end

    assign int_active = mip_value & mie_q;
    assign interrupt_pending = (|int_active) & mstatus_q[MSTATUS_MIE_BIT];

    // External first, then timer, then software
    always_comb begin
        if (int_active[M_EXT_CODE])
            int_code = M_EXT_CODE;
        else if (int_active[M_TIMER_CODE])
            int_code = M_TIMER_CODE;
        else
            int_code = M_SW_CODE;
    end

    // Timer and external follow their sources, msip can also be written
    always_ff @(posedge clk) begin
        if (rst) begin
            msip <= 1'b0;
            mtip <= 1'b0;
            meip <= 1'b0;
        end else begin
            mtip <= m_timer;
            meip <= m_external;
            if (m_software || wr_hit(SEL_MIP))
                msip <= m_software | wr_data[M_SW_CODE];
        end
    end

    ////////////////////////////////////////
    // Status and trap setup
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (trap_enter) begin
            mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT] <= 1'b0;
        end else if (mret) begin
            mstatus_q[MSTATUS_MIE_BIT] <= mstatus_q[MSTATUS_MPIE_BIT];
            mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (wr_hit(SEL_MSTATUS)) begin
            mstatus_q <= wr_data & MSTATUS_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q <= '0;
            mie_q <= '0;
            mscratch_q <= '0;
        end else begin
            // Direct mode only
            if (wr_hit(SEL_MTVEC))
                mtvec_q <= {wr_data[XLEN-1:2], 2'b00};
            if (wr_hit(SEL_MIE))
                mie_q <= wr_data & MIE_MASK;
            if (wr_hit(SEL_MSCRATCH))
                mscratch_q <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Trap handling
    assign cause_legal = wr_data[XLEN-1] ? INT_CODE_LEGAL[wr_data[ECODE_W-1:0]]
                                         : EXC_CODE_LEGAL[wr_data[ECODE_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q <= '0;
            mtval_q <= '0;
            mcause_int <= 1'b0;
            mcause_code <= '0;
        end else if (trap_enter) begin
            mepc_q <= {trap_pc[XLEN-1:2], 2'b00};
            mcause_int <= interrupt_take;
            mcause_code <= interrupt_take ? int_code : exception_code;
            // mtval only carries exception information
            if (!interrupt_take)
                mtval_q <= exception_tval;
        end else begin
            if (wr_hit(SEL_MEPC))
                mepc_q <= {wr_data[XLEN-1:2], 2'b00};
            if (wr_hit(SEL_MTVAL))
                mtval_q <= wr_data;
            // Illegal codes leave mcause untouched
            if (wr_hit(SEL_MCAUSE) && cause_legal) begin
                mcause_int <= wr_data[XLEN-1];
                mcause_code <= wr_data[ECODE_W-1:0];
            end
        end
    end

    assign trap_vector = mtvec_q;
    assign epc = mepc_q;

    ////////////////////////////////////////
    // Read mux
    always_comb begin
        case (rd_sel)
            SEL_MISA:     rd_regs = MISA_VALUE;
            SEL_MHARTID:  rd_regs = HART_ID;
            SEL_MSTATUS:  rd_regs = mstatus_q | MSTATUS_MPP_M;
            SEL_MTVEC:    rd_regs = mtvec_q;
            SEL_MIE:      rd_regs = mie_q;
            SEL_MIP:      rd_regs = mip_value;
            SEL_MSCRATCH: rd_regs = mscratch_q;
            SEL_MEPC:     rd_regs = mepc_q;
            SEL_MCAUSE:   rd_regs = {mcause_int, {(XLEN-1-ECODE_W){1'b0}}, mcause_code};
            SEL_MTVAL:    rd_regs = mtval_q;
            // Vendor, arch and impl IDs read zero, as do other blocks' selects
            default:      rd_regs = '0;
        endcase
    end

    // The core only takes an interrupt that this unit reports
    assert property (@(posedge clk) disable iff (rst) interrupt_take |-> interrupt_pending);

endmodule

`default_nettype wire

// ==== logic/csr_counters.sv ====
// Cycle and retired-instruction counters
`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  csr_sel_t    wr_sel,
    input  xlen_t       wr_data,
    input  csr_sel_t    rd_sel,
    input  retire_cnt_t retire_count,
    output xlen_t       rd_count
);

    counter_t mcycle;
    counter_t minstret;

    // A written half replaces the count, and the increment is dropped
    function automatic counter_t next_count(
        input counter_t cur,
        input logic     wr_lo,
        input logic     wr_hi,
        input counter_t inc
    );
        counter_t nxt;
        nxt = cur;
        if (wr_lo)
            nxt[XLEN-1:0] = wr_data;
        if (wr_hi)
            nxt[COUNTER_W-1:XLEN] = wr_data;
        if (!(wr_lo || wr_hi))
            nxt = nxt + inc;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= next_count(mcycle, wr_en && (wr_sel == SEL_MCYCLE),
                                 wr_en && (wr_sel == SEL_MCYCLEH), counter_t'(1));
            minstret <= next_count(minstret, wr_en && (wr_sel == SEL_MINSTRET),
                                   wr_en && (wr_sel == SEL_MINSTRETH),
                                   counter_t'(retire_count));
        end
    end

    always_comb begin
        case (rd_sel)
            SEL_MCYCLE:    rd_count = mcycle[XLEN-1:0];
            SEL_MCYCLEH:   rd_count = mcycle[COUNTER_W-1:XLEN];
            SEL_MINSTRET:  rd_count = minstret[XLEN-1:0];
            SEL_MINSTRETH: rd_count = minstret[COUNTER_W-1:XLEN];
            default:       rd_count = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/csr_unit.sv ====
// Machine-mode CSR unit
`default_nettype none

module csr_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Issue
    input  logic        issue_valid,
    output logic        issue_ready,
    input  csr_op_t     issue_op,
    input  csr_addr_t   issue_addr,
    input  xlen_t       issue_wdata,

    // Result
    output logic        result_done,
    output xlen_t       result_rdata,
    input  logic        result_ack,

    // Traps
    input  logic        exception_valid,
    input  ecode_t      exception_code,
    input  xlen_t       exception_tval,
    input  logic        interrupt_take,
    input  xlen_t       trap_pc,
    input  logic        mret,

    // Interrupt sources
    input  logic        m_software,
    input  logic        m_timer,
    input  logic        m_external,

    input  retire_cnt_t retire_count,

    output logic        interrupt_pending,
    output xlen_t       trap_vector,
    output xlen_t       epc
);

    logic wr_en;
    csr_sel_t wr_sel;
    xlen_t wr_data;
    xlen_t rd_regs;
    xlen_t rd_count;

    csr_cmd_if cmd ();

    csr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_addr  (issue_addr),
        .issue_wdata (issue_wdata),
        .result_ack  (result_ack),
        .cmd         (cmd)
    );

    csr_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .rd_regs      (rd_regs),
        .rd_count     (rd_count),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data),
        .result_done  (result_done),
        .result_rdata (result_rdata),
        .result_ack   (result_ack)
    );

    csr_machine_regs u_machine_regs (
        .clk               (clk),
        .rst               (rst),
        .wr_en             (wr_en),
        .wr_sel            (wr_sel),
        .wr_data           (wr_data),
        .rd_sel            (cmd.sel),
        .rd_regs           (rd_regs),
        .exception_valid   (exception_valid),
        .exception_code    (exception_code),
        .exception_tval    (exception_tval),
        .interrupt_take    (interrupt_take),
        .trap_pc           (trap_pc),
        .mret              (mret),
        .m_software        (m_software),
        .m_timer           (m_timer),
        .m_external        (m_external),
        .interrupt_pending (interrupt_pending),
        .trap_vector       (trap_vector),
        .epc               (epc)
    );

    csr_counters u_counters (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data),
        .rd_sel       (cmd.sel),
        .retire_count (retire_count),
        .rd_count     (rd_count)
    );

endmodule

`default_nettype wire

// ==== test/csr_unit_tb.sv ====
// CSR unit testbench
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int DONE_LIMIT = 16;
    // About 50 CSR accesses of at most 8 cycles, plus trap and counter phases
    localparam int ACCESS_BUDGET = 60;
    localparam int CYCLES_PER_ACCESS = 8;
    localparam int TIMEOUT_NS =
        (RESET_CYCLES + ACCESS_BUDGET * CYCLES_PER_ACCESS + 100) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    logic issue_ready;
    csr_op_t issue_op;
    csr_addr_t issue_addr;
    xlen_t issue_wdata;
    logic result_done;
    xlen_t result_rdata;
    logic result_ack;
    logic exception_valid;
    ecode_t exception_code;
    xlen_t exception_tval;
    logic interrupt_take;
    xlen_t trap_pc;
    logic mret;
    logic m_software;
    logic m_timer;
    logic m_external;
    retire_cnt_t retire_count;
    logic interrupt_pending;
    xlen_t trap_vector;
    xlen_t epc;

    int seed = 32'h9df0;
    int errors = 0;
    int results = 0;
    xlen_t exp_q[$];
    bit chk_q[$];

    // Reference model state
    xlen_t model_mstatus = '0;
    xlen_t model_mtvec = '0;
    xlen_t model_mie = '0;
    xlen_t model_mip = '0;
    xlen_t model_mscratch = '0;
    xlen_t model_mepc = '0;
    xlen_t model_mcause = '0;
    xlen_t model_mtval = '0;
    xlen_t model_minstret = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    csr_unit u_csr_unit (.*);

    ////////////////////////////////////////
    // Reference model
    function automatic bit cause_is_legal(input xlen_t v);
        if (v[31])
            return v[4:0] inside {M_SW_CODE, M_TIMER_CODE, M_EXT_CODE};
        return v[4:0] inside {5'd0, 5'd2, 5'd3, 5'd4, 5'd6, 5'd11};
    endfunction

    function automatic xlen_t expected_old(input csr_addr_t addr);
        case (addr)
            ADDR_MISA:     return MISA_VALUE;
            ADDR_MHARTID:  return HART_ID;
            // mpp always reads as machine mode
            ADDR_MSTATUS:  return model_mstatus | 32'h0000_1800;
            ADDR_MTVEC:    return model_mtvec;
            ADDR_MIE:      return model_mie;
            ADDR_MIP:      return model_mip;
            ADDR_MSCRATCH: return model_mscratch;
            ADDR_MEPC:     return model_mepc;
            ADDR_MCAUSE:   return model_mcause;
            ADDR_MTVAL:    return model_mtval;
            ADDR_MINSTRET: return model_minstret;
            default:       return '0;
        endcase
    endfunction

    function automatic void update_model(input csr_op_t op, input csr_addr_t addr,
                                         input xlen_t wdata);
        xlen_t old_v;
        xlen_t new_v;
        old_v = expected_old(addr);
        case (op)
            CSR_RS:  new_v = old_v | wdata;
            CSR_RC:  new_v = old_v & ~wdata;
            default: new_v = wdata;
        endcase
        case (addr)
            ADDR_MSTATUS:  model_mstatus = new_v & MSTATUS_MASK;
            ADDR_MTVEC:    model_mtvec = new_v & ~32'h3;
            ADDR_MIE:      model_mie = new_v & MIE_MASK;
            ADDR_MSCRATCH: model_mscratch = new_v;
            ADDR_MEPC:     model_mepc = new_v & ~32'h3;
            ADDR_MTVAL:    model_mtval = new_v;
            ADDR_MINSTRET: model_minstret = new_v;
            ADDR_MCAUSE: begin
                if (cause_is_legal(new_v))
                    model_mcause = new_v & 32'h8000_001F;
            end
            default: ;
        endcase
    endfunction

    // External over timer over software
    function automatic ecode_t interrupt_cause();
        xlen_t active;
        active = model_mip & model_mie;
        if (active[M_EXT_CODE])
            return M_EXT_CODE;
        if (active[M_TIMER_CODE])
            return M_TIMER_CODE;
        return M_SW_CODE;
    endfunction

    function automatic void enter_trap(input bit is_int, input ecode_t code,
                                       input xlen_t pc, input xlen_t tval);
        model_mstatus[MSTATUS_MPIE_BIT] = model_mstatus[MSTATUS_MIE_BIT];
        model_mstatus[MSTATUS_MIE_BIT] = 1'b0;
        model_mepc = pc & ~32'h3;
        model_mcause = {is_int, 26'd0, code};
        if (!is_int)
            model_mtval = tval;
    endfunction

    function automatic void leave_trap();
        model_mstatus[MSTATUS_MIE_BIT] = model_mstatus[MSTATUS_MPIE_BIT];
        model_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
    endfunction

    ////////////////////////////////////////
    // Reporting and bus tasks
    task automatic report_mismatch(input string name, input xlen_t actual,
                                   input xlen_t expected);
        errors++;
        $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h",
                 $time, name, actual, expected);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    // One CSR operation through both handshakes, old value returned
    task automatic csr_access(
        input  csr_op_t   op,
        input  csr_addr_t addr,
        input  xlen_t     wdata,
        input  bit        exact,
        output xlen_t     rdata
    );
        int waited;
        exp_q.push_back(expected_old(addr));
        chk_q.push_back(exact);
        update_model(op, addr, wdata);
        issue_valid <= 1'b1;
        issue_op <= op;
        issue_addr <= addr;
        issue_wdata <= wdata;
        @(posedge clk);
        while (!issue_ready)
            @(posedge clk);
        issue_valid <= 1'b0;
        waited = 0;
        @(posedge clk);
        while (!result_done && waited < DONE_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        rdata = result_rdata;
        if (!result_done) begin
            report_failure("no result_done after an accepted request");
        end else begin
            result_ack <= 1'b1;
            @(posedge clk);
            result_ack <= 1'b0;
        end
    endtask

    // Compare each result with the model at its ack edge
    always @(posedge clk) begin
        xlen_t expected;
        bit exact;
        if (!rst && result_done && result_ack) begin
            if (exp_q.size() == 0) begin
                report_failure("result_done without an issued request");
            end else begin
                expected = exp_q.pop_front();
                exact = chk_q.pop_front();
                if (exact) begin
                    results++;
                    if (result_rdata !== expected)
                        report_mismatch("result_rdata", result_rdata, expected);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus
    initial begin
        xlen_t rdata;
        xlen_t wdata;
        xlen_t pc;
        xlen_t tval;
        xlen_t first;
        xlen_t second;
        csr_op_t op;
        int waited;
        int retire_sum;
        retire_cnt_t retire_list[8];

        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = CSR_RW;
        issue_addr = '0;
        issue_wdata = '0;
        result_ack = 1'b0;
        exception_valid = 1'b0;
        exception_code = '0;
        exception_tval = '0;
        interrupt_take = 1'b0;
        trap_pc = '0;
        mret = 1'b0;
        m_software = 1'b0;
        m_timer = 1'b0;
        m_external = 1'b0;
        retire_count = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (!issue_ready || result_done || interrupt_pending)
            report_failure("handshake and interrupt outputs not idle after reset");

        // mscratch read-modify-write
        repeat (12) begin
            wdata = $random(seed);
            case ($unsigned($random(seed)) % 3)
                0:       op = CSR_RW;
                1:       op = CSR_RS;
                default: op = CSR_RC;
            endcase
            csr_access(op, ADDR_MSCRATCH, wdata, 1'b1, rdata);
        end
        csr_access(CSR_RS, ADDR_MSCRATCH, '0, 1'b1, rdata);

        // Constant, read-only and unknown addresses
        csr_access(CSR_RS, ADDR_MISA, '0, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MISA, $random(seed), 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MISA, '0, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MHARTID, $random(seed), 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MHARTID, '0, 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MVENDORID, '0, 1'b1, rdata);
        csr_access(CSR_RW, 12'h7C0, $random(seed), 1'b1, rdata);
        csr_access(CSR_RS, 12'h7C0, '0, 1'b1, rdata);

        // Masked registers
        wdata = $random(seed);
        csr_access(CSR_RW, ADDR_MTVEC, wdata, 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MTVEC, '0, 1'b1, rdata);
        if (trap_vector !== {wdata[31:2], 2'b00})
            report_mismatch("trap_vector", trap_vector, {wdata[31:2], 2'b00});
        csr_access(CSR_RW, ADDR_MEPC, $random(seed), 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MEPC, '0, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MSTATUS, 32'hFFFF_FFFF, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MSTATUS, '0, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MIE, 32'hFFFF_FFFF, 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MIE, '0, 1'b1, rdata);

        // Interrupt entry and mret
        csr_access(CSR_RW, ADDR_MSTATUS, 32'h0000_0008, 1'b1, rdata);
        m_timer <= 1'b1;
        m_external <= 1'b1;
        // Timer bit 7, external bit 11
        model_mip = 32'h0000_0880;
        waited = 0;
        while (!interrupt_pending && waited < DONE_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!interrupt_pending) begin
            report_failure("interrupt_pending stayed low with enabled sources");
        end else begin
            csr_access(CSR_RS, ADDR_MIP, '0, 1'b1, rdata);
            pc = $random(seed);
            interrupt_take <= 1'b1;
            trap_pc <= pc;
            @(posedge clk);
            interrupt_take <= 1'b0;
            m_timer <= 1'b0;
            m_external <= 1'b0;
            enter_trap(1'b1, interrupt_cause(), pc, '0);
            model_mip = '0;
            @(posedge clk);
            if (epc !== model_mepc)
                report_mismatch("epc", epc, model_mepc);
            csr_access(CSR_RS, ADDR_MCAUSE, '0, 1'b1, rdata);
            csr_access(CSR_RS, ADDR_MEPC, '0, 1'b1, rdata);
            csr_access(CSR_RS, ADDR_MSTATUS, '0, 1'b1, rdata);
            mret <= 1'b1;
            @(posedge clk);
            mret <= 1'b0;
            leave_trap();
            csr_access(CSR_RS, ADDR_MSTATUS, '0, 1'b1, rdata);
        end

        // Exception entry, then illegal mcause writes
        pc = $random(seed) & ~32'h3;
        tval = $random(seed);
        exception_valid <= 1'b1;
        exception_code <= 5'd2;
        exception_tval <= tval;
        trap_pc <= pc;
        @(posedge clk);
        exception_valid <= 1'b0;
        enter_trap(1'b0, 5'd2, pc, tval);
        @(posedge clk);
        if (epc !== pc)
            report_mismatch("epc", epc, pc);
        csr_access(CSR_RS, ADDR_MCAUSE, '0, 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MTVAL, '0, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MCAUSE, 32'd9, 1'b1, rdata);
        csr_access(CSR_RW, ADDR_MCAUSE, 32'h8000_0005, 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MCAUSE, '0, 1'b1, rdata);

        // minstret sums a known retire pattern
        retire_list = '{2'd1, 2'd2, 2'd0, 2'd2, 2'd1, 2'd1, 2'd2, 2'd0};
        retire_sum = 0;
        foreach (retire_list[i]) begin
            retire_count <= retire_list[i];
            retire_sum += int'(retire_list[i]);
            @(posedge clk);
        end
        retire_count <= '0;
        @(posedge clk);
        model_minstret = model_minstret + xlen_t'(retire_sum);
        csr_access(CSR_RS, ADDR_MINSTRET, '0, 1'b1, rdata);
        csr_access(CSR_RS, ADDR_MINSTRETH, '0, 1'b1, rdata);

        // mcycle keeps counting from a written value
        wdata = $random(seed) & 32'h7FFF_FFFF;
        csr_access(CSR_RW, ADDR_MCYCLE, wdata, 1'b0, rdata);
        csr_access(CSR_RS, ADDR_MCYCLE, '0, 1'b0, first);
        csr_access(CSR_RS, ADDR_MCYCLE, '0, 1'b0, second);
        if (first < wdata) begin
            errors++;
            $display("** Error at %0d ns: mcycle = 0x%08h, expected at least 0x%08h",
                     $time, first, wdata);
        end
        if (second <= first) begin
            errors++;
            $display("** Error at %0d ns: mcycle = 0x%08h, expected above 0x%08h",
                     $time, second, first);
        end

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0)
            report_failure("results missing for accepted requests");
        $display("Summary: %0d results compared, %0d errors", results, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
logic/csr_pkg.sv
logic/csr_cmd_if.sv
logic/csr_decode.sv
logic/csr_execute.sv
logic/csr_machine_regs.sv
logic/csr_counters.sv
logic/csr_unit.sv
test/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module csr_unit_tb \
    -f csr_unit.f

./obj_dir/Vcsr_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
